// ==== axi_lite_mem.f ====
+incdir+design
design/axi_lite_pkg.sv
design/axi4_lite_master_write.sv
design/axi4_lite_master_read.sv
design/axi4_lite_slave_mem.sv
design/axi_lite_mem_top.sv
verification/axi_lite_mem_tb.sv

// ==== design/axi4_lite_master_read.sv ====
// AXI4-Lite read master
`timescale 1ns/10ps

module axi4_lite_master_read (
    // Clock and reset.
    input  logic                clk,
    input  logic                arstn,

    // Request side.
    input  logic                i_start,
    input  axi_lite_pkg::addr_t i_addr,
    output logic                o_done,
    output logic                o_fault,
    output axi_lite_pkg::data_t o_data,

    // Read address channel.
    input  logic                i_ar_ready,
    output logic                o_ar_valid,
    output axi_lite_pkg::addr_t o_ar_addr,

    // Read data channel.
    input  logic                i_r_valid,
    input  axi_lite_pkg::data_t i_r_data,
    input  axi_lite_pkg::resp_t i_r_resp,
    output logic                o_r_ready
);

    // --------------------------------------------------------------------------
    // FSM.
    // --------------------------------------------------------------------------

    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        AR_READ = 2'b10,
        RESP    = 2'b11
    } state_t;

    state_t state;
    state_t next_state;

    // Channel handshakes.
    logic ar_hs;
    logic r_hs;

    assign ar_hs = o_ar_valid & i_ar_ready;
    assign r_hs  = i_r_valid  & o_r_ready;

    // State register.
    always_ff @(posedge clk, negedge arstn) begin
        if (~arstn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Next state.
    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (i_start) next_state = AR_READ;
            AR_READ: if (ar_hs)   next_state = RESP;
            RESP:    if (r_hs)    next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // --------------------------------------------------------------------------
    // Channel control, data capture and done pulse.
    // --------------------------------------------------------------------------

    always_ff @(posedge clk, negedge arstn) begin
        if (~arstn) begin
            o_ar_valid <= 1'b0;
            o_r_ready  <= 1'b0;
            o_done     <= 1'b0;
            o_fault    <= 1'b0;
            o_data     <= '0;
        end else begin
            o_done  <= 1'b0;
            o_fault <= 1'b0;
            case (state)
                IDLE: if (i_start) begin
                    o_ar_valid <= 1'b1;
                end
                // Ready for the response once the address is taken.
                AR_READ: if (ar_hs) begin
                    o_ar_valid <= 1'b0;
                    o_r_ready  <= 1'b1;
                end
                // Data holds until the next read completes.
                RESP: if (r_hs) begin
                    o_r_ready <= 1'b0;
                    o_data    <= i_r_data;
                    o_done    <= 1'b1;
                    o_fault   <= (i_r_resp == axi_lite_pkg::RESP_SLVERR);
                end
                default: begin
                    o_ar_valid <= 1'b0;
                    o_r_ready  <= 1'b0;
                end
            endcase
        end
    end

    // Address captured at start.
    always_ff @(posedge clk) begin
        if ((state == IDLE) && i_start) begin
            o_ar_addr <= i_addr;
        end
    end

endmodule

// ==== design/axi4_lite_master_write.sv ====
// AXI4-Lite write master
`timescale 1ns/10ps

module axi4_lite_master_write (
    // Clock and reset.
    input  logic                clk,
    input  logic                arstn,

    // Request side.
    input  axi_lite_pkg::addr_t i_addr,
    input  axi_lite_pkg::data_t i_data,
    input  logic                i_start,
    output logic                o_done,
    output logic                o_fault,

    // Write address channel.
    input  logic                i_aw_ready,
    output logic                o_aw_valid,
    output axi_lite_pkg::addr_t o_aw_addr,

    // Write data channel.
    input  logic                i_w_ready,
    output logic                o_w_valid,
    output axi_lite_pkg::data_t o_w_data,

    // Write response channel.
    input  logic                i_b_valid,
    input  axi_lite_pkg::resp_t i_b_resp,
    output logic                o_b_ready
);

    // --------------------------------------------------------------------------
    // FSM.
    // --------------------------------------------------------------------------

    // One state per channel phase.
    typedef enum logic [1:0] {
        IDLE     = 2'b00,
        AW_WRITE = 2'b10,
        WRITE    = 2'b01,
        RESP     = 2'b11
    } state_t;

    state_t state;
    state_t next_state;

    // Handshakes on each channel.
    logic aw_hs;
    logic w_hs;
    logic b_hs;

    assign aw_hs = o_aw_valid & i_aw_ready;
    assign w_hs  = o_w_valid  & i_w_ready;
    assign b_hs  = i_b_valid  & o_b_ready;

    // State register.
    always_ff @(posedge clk, negedge arstn) begin
        if (~arstn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Next state.
    // Start is only seen in IDLE, so a pulse while busy is dropped.
    always_comb begin
        next_state = state;
        case (state)
            IDLE:     if (i_start) next_state = AW_WRITE;
            AW_WRITE: if (aw_hs)   next_state = WRITE;
            WRITE:    if (w_hs)    next_state = RESP;
            RESP:     if (b_hs)    next_state = IDLE;
            default:  next_state = IDLE;
        endcase
    end

    // --------------------------------------------------------------------------
    // Channel control and done pulse.
    // --------------------------------------------------------------------------

    always_ff @(posedge clk, negedge arstn) begin
        if (~arstn) begin
            o_aw_valid <= 1'b0;
            o_w_valid  <= 1'b0;
            o_b_ready  <= 1'b0;
            o_done     <= 1'b0;
            o_fault    <= 1'b0;
        end else begin
            // Done and fault are single cycle pulses.
            o_done  <= 1'b0;
            o_fault <= 1'b0;
            case (state)
                IDLE: if (i_start) begin
                    o_aw_valid <= 1'b1;
                end
                // Data phase starts the cycle after the address handshake.
                AW_WRITE: if (aw_hs) begin
                    o_aw_valid <= 1'b0;
                    o_w_valid  <= 1'b1;
                end
                WRITE: if (w_hs) begin
                    o_w_valid <= 1'b0;
                    o_b_ready <= 1'b1;
                end
                // Bit 1 set means SLVERR or DECERR.
                RESP: if (b_hs) begin
                    o_b_ready <= 1'b0;
                    o_done    <= 1'b1;
                    o_fault   <= i_b_resp[1];
                end
                default: begin
                    o_aw_valid <= 1'b0;
                    o_w_valid  <= 1'b0;
                    o_b_ready  <= 1'b0;
                end
            endcase
        end
    end

    // Request captured at start so the user may change it afterwards.
    always_ff @(posedge clk) begin
        if ((state == IDLE) && i_start) begin
            o_aw_addr <= i_addr;
            o_w_data  <= i_data;
        end
    end

endmodule

// ==== design/axi4_lite_slave_mem.sv ====
// AXI4-Lite slave memory
`timescale 1ns/10ps
`include "axi_lite_macros.svh"

module axi4_lite_slave_mem (
    // Clock and reset.
    input  logic                clk,
    input  logic                arstn,

    // Write side.
    input  logic                i_aw_valid,
    input  axi_lite_pkg::addr_t i_aw_addr,
    output logic                o_aw_ready,
    input  logic                i_w_valid,
    input  axi_lite_pkg::data_t i_w_data,
    output logic                o_w_ready,
    input  logic                i_b_ready,
    output logic                o_b_valid,
    output axi_lite_pkg::resp_t o_b_resp,

    // Read side.
    input  logic                i_ar_valid,
    input  axi_lite_pkg::addr_t i_ar_addr,
    output logic                o_ar_ready,
    input  logic                i_r_ready,
    output logic                o_r_valid,
    output axi_lite_pkg::data_t o_r_data,
    output axi_lite_pkg::resp_t o_r_resp
);

    // Word index width.
    localparam int IDX_W = $clog2(`AXI_MEM_DEPTH);

    // Word array shared by both sides.
    axi_lite_pkg::data_t mem [0:`AXI_MEM_DEPTH-1];

    // --------------------------------------------------------------------------
    // Address decode.
    // --------------------------------------------------------------------------

    // Write address, held from AW until the data arrives.
    axi_lite_pkg::addr_t aw_addr_q;

    logic [IDX_W-1:0] w_idx;
    logic [IDX_W-1:0] r_idx;
    logic             w_in_range;
    logic             r_in_range;

    // Low two bits dropped, word aligned.
    assign w_idx      = aw_addr_q[IDX_W+1:2];
    assign r_idx      = i_ar_addr[IDX_W+1:2];
    assign w_in_range = aw_addr_q[`AXI_ADDR_WIDTH-1:2] < `AXI_MEM_DEPTH;
    assign r_in_range = i_ar_addr[`AXI_ADDR_WIDTH-1:2] < `AXI_MEM_DEPTH;

    // Handshakes.
    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic ar_hs;
    logic r_hs;

    assign aw_hs = i_aw_valid & o_aw_ready;
    assign w_hs  = i_w_valid  & o_w_ready;
    assign b_hs  = o_b_valid  & i_b_ready;
    assign ar_hs = i_ar_valid & o_ar_ready;
    assign r_hs  = o_r_valid  & i_r_ready;

    // --------------------------------------------------------------------------
    // Write side.
    // --------------------------------------------------------------------------

    typedef enum logic [1:0] {
        W_IDLE = 2'b00,
        W_DATA = 2'b01,
        W_RESP = 2'b10
    } w_state_t;

    w_state_t w_state;

    // Ready rises the first cycle out of reset.
    always_ff @(posedge clk, negedge arstn) begin
        if (~arstn) begin
            w_state    <= W_IDLE;
            o_aw_ready <= 1'b0;
            o_w_ready  <= 1'b0;
            o_b_valid  <= 1'b0;
        end else begin
            case (w_state)
                W_IDLE: begin
                    if (aw_hs) begin
                        o_aw_ready <= 1'b0;
                        o_w_ready  <= 1'b1;
                        w_state    <= W_DATA;
                    end else begin
                        o_aw_ready <= 1'b1;
                    end
                end
                // Response follows the cycle after the data.
                W_DATA: if (w_hs) begin
                    o_w_ready <= 1'b0;
                    o_b_valid <= 1'b1;
                    w_state   <= W_RESP;
                end
                W_RESP: if (b_hs) begin
                    o_b_valid  <= 1'b0;
                    o_aw_ready <= 1'b1;
                    w_state    <= W_IDLE;
                end
                default: begin
                    o_aw_ready <= 1'b0;
                    o_w_ready  <= 1'b0;
                    o_b_valid  <= 1'b0;
                    w_state    <= W_IDLE;
                end
            endcase
        end
    end

    // Address latch and write response code.
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            aw_addr_q <= i_aw_addr;
        end
        if (w_hs) begin
            o_b_resp <= w_in_range ? axi_lite_pkg::RESP_OKAY : axi_lite_pkg::RESP_SLVERR;
        end
    end

    // Memory array, cleared on reset.
    // Out of range writes leave it untouched.
    always_ff @(posedge clk, negedge arstn) begin
        if (~arstn) begin
            for (int i = 0; i < `AXI_MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (w_hs && w_in_range) begin
            mem[w_idx] <= i_w_data;
        end
    end

    // --------------------------------------------------------------------------
    // Read side.
    // --------------------------------------------------------------------------

    typedef enum logic {
        R_IDLE = 1'b0,
        R_RESP = 1'b1
    } r_state_t;

    r_state_t r_state;

    always_ff @(posedge clk, negedge arstn) begin
        if (~arstn) begin
            r_state    <= R_IDLE;
            o_ar_ready <= 1'b0;
            o_r_valid  <= 1'b0;
        end else begin
            case (r_state)
                R_IDLE: begin
                    if (ar_hs) begin
                        o_ar_ready <= 1'b0;
                        o_r_valid  <= 1'b1;
                        r_state    <= R_RESP;
                    end else begin
                        o_ar_ready <= 1'b1;
                    end
                end
                R_RESP: if (r_hs) begin
                    o_r_valid  <= 1'b0;
                    o_ar_ready <= 1'b1;
                    r_state    <= R_IDLE;
                end
                default: r_state <= R_IDLE;
            endcase
        end
    end

    // Read data sampled before any write on the same edge lands.
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            if (r_in_range) begin
                o_r_data <= mem[r_idx];
                o_r_resp <= axi_lite_pkg::RESP_OKAY;
            end else begin
                o_r_data <= '0;
                o_r_resp <= axi_lite_pkg::RESP_SLVERR;
            end
        end
    end

endmodule

// ==== design/axi_lite_macros.svh ====
// AXI4-Lite subsystem parameters
`ifndef AXI_LITE_MACROS_SVH
`define AXI_LITE_MACROS_SVH

// --------------------------------------------------------------------------
// Bus widths.
// --------------------------------------------------------------------------

// Byte address width.
`define AXI_ADDR_WIDTH 32

// Width of one data word.
`define AXI_DATA_WIDTH 32

// --------------------------------------------------------------------------
// Slave memory.
// --------------------------------------------------------------------------

// Number of words, a power of two.
`define AXI_MEM_DEPTH 64

`endif

// ==== design/axi_lite_mem_top.sv ====
// AXI4-Lite memory subsystem top
`timescale 1ns/10ps

module axi_lite_mem_top (
    // Clock and reset.
    input  logic                clk,
    input  logic                arstn,

    // Write request port.
    input  logic                i_wr_start,
    input  axi_lite_pkg::addr_t i_wr_addr,
    input  axi_lite_pkg::data_t i_wr_data,
    output logic                o_wr_done,
    output logic                o_wr_fault,

    // Read request port.
    input  logic                i_rd_start,
    input  axi_lite_pkg::addr_t i_rd_addr,
    output logic                o_rd_done,
    output logic                o_rd_fault,
    output axi_lite_pkg::data_t o_rd_data
);

    // --------------------------------------------------------------------------
    // Write channel group.
    // --------------------------------------------------------------------------

    logic                aw_valid;
    logic                aw_ready;
    axi_lite_pkg::addr_t aw_addr;
    logic                w_valid;
    logic                w_ready;
    axi_lite_pkg::data_t w_data;
    logic                b_valid;
    logic                b_ready;
    axi_lite_pkg::resp_t b_resp;

    // --------------------------------------------------------------------------
    // Read channel group.
    // --------------------------------------------------------------------------

    logic                ar_valid;
    logic                ar_ready;
    axi_lite_pkg::addr_t ar_addr;
    logic                r_valid;
    logic                r_ready;
    axi_lite_pkg::data_t r_data;
    axi_lite_pkg::resp_t r_resp;

    // Write master.
    axi4_lite_master_write u_master_write (
        .clk        (clk),
        .arstn      (arstn),
        .i_addr     (i_wr_addr),
        .i_data     (i_wr_data),
        .i_start    (i_wr_start),
        .o_done     (o_wr_done),
        .o_fault    (o_wr_fault),
        .i_aw_ready (aw_ready),
        .o_aw_valid (aw_valid),
        .o_aw_addr  (aw_addr),
        .i_w_ready  (w_ready),
        .o_w_valid  (w_valid),
        .o_w_data   (w_data),
        .i_b_valid  (b_valid),
        .i_b_resp   (b_resp),
        .o_b_ready  (b_ready)
    );

    // Read master.
    axi4_lite_master_read u_master_read (
        .clk        (clk),
        .arstn      (arstn),
        .i_start    (i_rd_start),
        .i_addr     (i_rd_addr),
        .o_done     (o_rd_done),
        .o_fault    (o_rd_fault),
        .o_data     (o_rd_data),
        .i_ar_ready (ar_ready),
        .o_ar_valid (ar_valid),
        .o_ar_addr  (ar_addr),
        .i_r_valid  (r_valid),
        .i_r_data   (r_data),
        .i_r_resp   (r_resp),
        .o_r_ready  (r_ready)
    );

    // Slave memory serving both channel groups.
    axi4_lite_slave_mem u_slave_mem (
        .clk        (clk),
        .arstn      (arstn),
        .i_aw_valid (aw_valid),
        .i_aw_addr  (aw_addr),
        .o_aw_ready (aw_ready),
        .i_w_valid  (w_valid),
        .i_w_data   (w_data),
        .o_w_ready  (w_ready),
        .i_b_ready  (b_ready),
        .o_b_valid  (b_valid),
        .o_b_resp   (b_resp),
        .i_ar_valid (ar_valid),
        .i_ar_addr  (ar_addr),
        .o_ar_ready (ar_ready),
        .i_r_ready  (r_ready),
        .o_r_valid  (r_valid),
        .o_r_data   (r_data),
        .o_r_resp   (r_resp)
    );

endmodule

// ==== design/axi_lite_pkg.sv ====
// AXI4-Lite shared types
`include "axi_lite_macros.svh"

package axi_lite_pkg;

    // ----------------------------------------------------------------------
    // Vector types.
    // ----------------------------------------------------------------------

    // Byte address on the AW and AR channels.
    typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;

    // One data word on the W and R channels.
    typedef logic [`AXI_DATA_WIDTH-1:0] data_t;

    // Response code on the B and R channels.
    typedef logic [1:0] resp_t;

    // ----------------------------------------------------------------------
    // Response codes.
    // ----------------------------------------------------------------------

    // Normal completion.
    localparam resp_t RESP_OKAY   = 2'b00;

    // Slave error, used here for out of range addresses.
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the AXI4-Lite memory testbench with Verilator and runs it.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
    -f axi_lite_mem.f \
    --top-module axi_lite_mem_tb \
    -o axi_lite_mem_sim

./obj_dir/axi_lite_mem_sim | tee sim.log

# The testbench prints the pass line only when every check held.
if grep -qx "Done: no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// ==== verification/axi_lite_mem_tb.sv ====
// AXI4-Lite memory subsystem testbench
`timescale 1ns/10ps
`include "axi_lite_macros.svh"

module axi_lite_mem_tb;

    // Roughly 95 transactions over all tests.
    localparam int NUM_TRANS   = 100;
    localparam int MAX_CYCLES  = 40 * NUM_TRANS + 200;
    localparam int RANGE_BYTES = 4 * `AXI_MEM_DEPTH;
    localparam int IDX_W       = $clog2(`AXI_MEM_DEPTH);

    logic                clk;
    logic                arstn;
    logic                i_wr_start;
    logic                i_rd_start;
    axi_lite_pkg::addr_t i_wr_addr;
    axi_lite_pkg::addr_t i_rd_addr;
    axi_lite_pkg::data_t i_wr_data;
    logic                o_wr_done;
    logic                o_wr_fault;
    logic                o_rd_done;
    logic                o_rd_fault;
    axi_lite_pkg::data_t o_rd_data;

    // Reference memory and the values expected at the next done.
    axi_lite_pkg::data_t ref_mem [0:`AXI_MEM_DEPTH-1];
    logic                exp_wr_fault;
    logic                exp_rd_fault;
    axi_lite_pkg::data_t exp_rd_data;

    int          error_count;
    int          test_count;
    int          trans_count;
    int          cycle_count;
    int          wr_done_count;
    int          rd_done_count;
    logic [31:0] rng_state;

    axi_lite_mem_top dut0 (
        .clk        (clk),
        .arstn      (arstn),
        .i_wr_start (i_wr_start),
        .i_wr_addr  (i_wr_addr),
        .i_wr_data  (i_wr_data),
        .o_wr_done  (o_wr_done),
        .o_wr_fault (o_wr_fault),
        .i_rd_start (i_rd_start),
        .i_rd_addr  (i_rd_addr),
        .o_rd_done  (o_rd_done),
        .o_rd_fault (o_rd_fault),
        .o_rd_data  (o_rd_data)
    );

    // 100 ns clock.
    always #50 clk = ~clk;

    // Done pulses counted mid-cycle, away from the active edge.
    always @(negedge clk) begin
        if (o_wr_done) wr_done_count++;
        if (o_rd_done) rd_done_count++;
    end

    // Run limit.
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("timeout after %0d cycles, a done pulse never came", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Done-cycle checks.
    // ------------------------------------------------------------------------

    wr_fault_chk: assert property (@(posedge clk) disable iff (!arstn)
        o_wr_done |-> (o_wr_fault == exp_wr_fault))
        else begin
            error_count++;
            $display("error o_wr_fault expected %h got %h",
                     $sampled(exp_wr_fault), $sampled(o_wr_fault));
        end

    rd_fault_chk: assert property (@(posedge clk) disable iff (!arstn)
        o_rd_done |-> (o_rd_fault == exp_rd_fault))
        else begin
            error_count++;
            $display("error o_rd_fault expected %h got %h",
                     $sampled(exp_rd_fault), $sampled(o_rd_fault));
        end

    rd_data_chk: assert property (@(posedge clk) disable iff (!arstn)
        o_rd_done |-> (o_rd_data == exp_rd_data))
        else begin
            error_count++;
            $display("error o_rd_data expected %h got %h",
                     $sampled(exp_rd_data), $sampled(o_rd_data));
        end

    // Single-cycle pulses, and no fault without done.
    wr_pulse_chk: assert property (@(posedge clk) disable iff (!arstn)
        o_wr_done |=> !o_wr_done)
        else begin
            error_count++;
            $display("write done stayed high for more than one cycle");
        end

    rd_pulse_chk: assert property (@(posedge clk) disable iff (!arstn)
        o_rd_done |=> !o_rd_done)
        else begin
            error_count++;
            $display("read done stayed high for more than one cycle");
        end

    fault_chk: assert property (@(posedge clk) disable iff (!arstn)
        (!o_wr_fault || o_wr_done) && (!o_rd_fault || o_rd_done))
        else begin
            error_count++;
            $display("a fault flag was raised outside its done cycle");
        end

    // ------------------------------------------------------------------------
    // Helpers.
    // ------------------------------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic addr_in_range(input axi_lite_pkg::addr_t addr);
        return addr < RANGE_BYTES;
    endfunction

    task automatic check_low(input string name, input logic value);
        assert (value === 1'b0) else begin
            error_count++;
            $display("error %s expected %h got %h", name, 1'b0, value);
        end
    endtask

    // Out of range writes give a fault.
    task automatic expect_write(input axi_lite_pkg::addr_t addr);
        exp_wr_fault = !addr_in_range(addr);
    endtask

    // Out of range reads give a fault and zero data.
    task automatic expect_read(input axi_lite_pkg::addr_t addr);
        exp_rd_fault = !addr_in_range(addr);
        exp_rd_data  = addr_in_range(addr) ? ref_mem[addr[IDX_W+1:2]] : '0;
    endtask

    task automatic commit_write(input axi_lite_pkg::addr_t addr, input axi_lite_pkg::data_t data);
        if (addr_in_range(addr)) begin
            ref_mem[addr[IDX_W+1:2]] = data;
        end
    endtask

    // Lets any stray done arrive, then checks the pulse totals.
    task automatic check_done_counts(input int wr_target, input int rd_target);
        repeat (6) @(negedge clk);
        assert (wr_done_count == wr_target) else begin
            error_count++;
            $display("write gave %0d done pulses, expected %0d", wr_done_count, wr_target);
        end
        assert (rd_done_count == rd_target) else begin
            error_count++;
            $display("read gave %0d done pulses, expected %0d", rd_done_count, rd_target);
        end
    endtask

    task automatic write_word(input axi_lite_pkg::addr_t addr, input axi_lite_pkg::data_t data);
        int target;
        @(negedge clk);
        expect_write(addr);
        target = wr_done_count + 1;
        @(posedge clk);
        i_wr_addr  <= addr;
        i_wr_data  <= data;
        i_wr_start <= 1'b1;
        @(posedge clk);
        i_wr_start <= 1'b0;
        wait (wr_done_count == target);
        commit_write(addr, data);
        trans_count++;
        check_done_counts(target, rd_done_count);
    endtask

    task automatic read_word(input axi_lite_pkg::addr_t addr);
        int target;
        @(negedge clk);
        expect_read(addr);
        target = rd_done_count + 1;
        @(posedge clk);
        i_rd_addr  <= addr;
        i_rd_start <= 1'b1;
        @(posedge clk);
        i_rd_start <= 1'b0;
        wait (rd_done_count == target);
        trans_count++;
        check_done_counts(wr_done_count, target);
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("test %0d %s finished, errors so far %0d", test_count, name, error_count);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence.
    // ------------------------------------------------------------------------

    initial begin
        axi_lite_pkg::addr_t addr;
        axi_lite_pkg::data_t data;
        int                  wr_target;
        int                  rd_target;

        clk           = 1'b0;
        arstn         = 1'b0;
        i_wr_start    = 1'b0;
        i_rd_start    = 1'b0;
        i_wr_addr     = '0;
        i_rd_addr     = '0;
        i_wr_data     = '0;
        exp_wr_fault  = 1'b0;
        exp_rd_fault  = 1'b0;
        exp_rd_data   = '0;
        error_count   = 0;
        test_count    = 0;
        trans_count   = 0;
        cycle_count   = 0;
        wr_done_count = 0;
        rd_done_count = 0;
        rng_state     = 32'd90;
        for (int i = 0; i < `AXI_MEM_DEPTH; i++) begin
            ref_mem[i] = '0;
        end

        // Reset for 5 cycles.
        repeat (5) @(posedge clk);
        arstn <= 1'b1;
        @(negedge clk);
        check_low("o_wr_done", o_wr_done);
        check_low("o_wr_fault", o_wr_fault);
        check_low("o_rd_done", o_rd_done);
        check_low("o_rd_fault", o_rd_fault);
        read_word(32'h0);
        read_word(32'h4);
        report_test("reset state");

        // Write then read back.
        write_word(32'h0000_0010, 32'hcafe_f00d);
        read_word(32'h0000_0010);
        report_test("write and read back");

        // Random traffic in the lower half, so reads often hit written words.
        for (int n = 0; n < 40; n++) begin
            rng_state = xorshift32(rng_state);
            addr      = rng_state % (RANGE_BYTES / 2);
            rng_state = xorshift32(rng_state);
            data      = rng_state;
            write_word(addr, data);
            rng_state = xorshift32(rng_state);
            read_word(rng_state % (RANGE_BYTES / 2));
        end
        write_word(32'h0000_0020, 32'h1111_1111);
        write_word(32'h0000_0020, 32'h2222_2222);
        read_word(32'h0000_0020);
        report_test("random traffic");

        // Out of range; the aliased word at index 2 must stay as it was.
        write_word(RANGE_BYTES + 32'h8, 32'hdead_beef);
        read_word(32'h0000_0008);
        read_word(RANGE_BYTES + 32'h8);
        report_test("out of range");

        // Simultaneous write and read to different words.
        write_word(32'h0000_0030, 32'h3333_3333);
        @(negedge clk);
        expect_write(32'h0000_0034);
        expect_read(32'h0000_0030);
        wr_target = wr_done_count + 1;
        rd_target = rd_done_count + 1;
        @(posedge clk);
        i_wr_addr  <= 32'h0000_0034;
        i_wr_data  <= 32'h4444_4444;
        i_wr_start <= 1'b1;
        i_rd_addr  <= 32'h0000_0030;
        i_rd_start <= 1'b1;
        @(posedge clk);
        i_wr_start <= 1'b0;
        i_rd_start <= 1'b0;
        wait (wr_done_count == wr_target);
        commit_write(32'h0000_0034, 32'h4444_4444);
        wait (rd_done_count == rd_target);
        trans_count += 2;
        check_done_counts(wr_target, rd_target);
        read_word(32'h0000_0034);
        report_test("concurrent write and read");

        // Second start while busy must be dropped.
        @(negedge clk);
        expect_write(32'h0000_0040);
        wr_target = wr_done_count + 1;
        @(posedge clk);
        i_wr_addr  <= 32'h0000_0040;
        i_wr_data  <= 32'h5555_5555;
        i_wr_start <= 1'b1;
        @(posedge clk);
        i_wr_start <= 1'b0;
        @(posedge clk);
        i_wr_addr  <= 32'h0000_0044;
        i_wr_data  <= 32'h6666_6666;
        i_wr_start <= 1'b1;
        @(posedge clk);
        i_wr_start <= 1'b0;
        wait (wr_done_count == wr_target);
        commit_write(32'h0000_0040, 32'h5555_5555);
        trans_count++;
        check_done_counts(wr_target, rd_done_count);
        read_word(32'h0000_0040);
        read_word(32'h0000_0044);
        report_test("start while busy");

        $display("tests %0d, transactions %0d, errors %0d", test_count, trans_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
